// File: rtl/fir_cfg.svh
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

// Bank geometry.
`define FIR_LANES 4
`define FIR_TAPS 20
`define FIR_STEPS 5

// Accumulator bit where the 5-bit result starts.
`define FIR_RES_LSB 9

// Coefficient k weights the pair tap k plus tap 19-k.
`define FIR_C0 9'h001
`define FIR_C1 9'h1F7
`define FIR_C2 9'h1FE
`define FIR_C3 9'h00D
`define FIR_C4 9'h00E
`define FIR_C5 9'h1F2
`define FIR_C6 9'h1D9
`define FIR_C7 9'h1FD
`define FIR_C8 9'h063
`define FIR_C9 9'h0C1

`endif

// File: rtl/dsp_types_pkg.sv
package dsp_types_pkg;

	typedef logic signed [4:0] sample_t;

	typedef logic signed [8:0] coef_t;

	// One extra bit so two samples never overflow.
	typedef logic signed [5:0] pair_t;

	typedef logic signed [14:0] prod_t;

	typedef logic signed [19:0] acc_t;

	// STEPn is encoded as n plus one.
	typedef enum logic [2:0]
	{
		LANE_IDLE,
		STEP0,
		STEP1,
		STEP2,
		STEP3,
		STEP4
	} lane_step_t;

endpackage

// File: rtl/chan_pkg.sv
package chan_pkg;

	typedef logic [1:0] chan_t;

	// Sample entering the bank.
	typedef struct packed
	{
		chan_t chan;
		dsp_types_pkg::sample_t sample;
	} in_beat_t;

	// Filtered result leaving the bank.
	typedef struct packed
	{
		chan_t chan;
		dsp_types_pkg::sample_t result;
	} out_beat_t;

	// Channel of a discarded sample.
	typedef struct packed
	{
		chan_t chan;
	} drop_t;

endpackage

// File: rtl/tap_delay_line.sv
`include "fir_cfg.svh"

module tap_delay_line (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic                       shift,
	input  dsp_types_pkg::sample_t     sample,
	input  dsp_types_pkg::lane_step_t  step,
	output dsp_types_pkg::pair_t       pair_a,
	output dsp_types_pkg::pair_t       pair_b
);
	import dsp_types_pkg::*;

	sample_t taps [`FIR_TAPS]; // Index 0 is the newest sample.
	logic [4:0] k_a;
	logic [4:0] k_b;

	always_ff @(posedge clk, negedge resetn)
	begin
		if (!resetn)
		begin
			taps <= '{default: '0};
		end
		else if (shift)
		begin
			for (int i = `FIR_TAPS - 1; i > 0; i--)
			begin
				taps[i] <= taps[i - 1];
			end
			taps[0] <= sample;
		end
	end

	always_comb
	begin
		case (step)
			STEP0: k_a = 5'd0;
			STEP1: k_a = 5'd2;
			STEP2: k_a = 5'd4;
			STEP3: k_a = 5'd6;
			STEP4: k_a = 5'd8;
			default: k_a = 5'd0;
		endcase
		k_b = k_a + 5'd1;
	end

	// Fold mirrored taps.
	assign pair_a = pair_t'(taps[k_a]) + pair_t'(taps[`FIR_TAPS - 1 - k_a]);
	assign pair_b = pair_t'(taps[k_b]) + pair_t'(taps[`FIR_TAPS - 1 - k_b]);

endmodule

// File: rtl/fir_lane.sv
`include "fir_cfg.svh"

module fir_lane (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    start,
	input  dsp_types_pkg::sample_t  sample,
	output logic                    busy,
	output logic                    res_valid,
	output dsp_types_pkg::sample_t  res
);
	import dsp_types_pkg::*;

	localparam lane_step_t LAST_STEP = lane_step_t'(`FIR_STEPS);

	lane_step_t state_q;
	lane_step_t state_d;
	pair_t pair_a;
	pair_t pair_b;
	coef_t coef_a;
	coef_t coef_b;
	prod_t prod_a;
	prod_t prod_b;
	acc_t acc_q;
	acc_t acc_d;

	tap_delay_line u_tap_delay_line (
		.clk    (clk),
		.resetn (resetn),
		.shift  (start),
		.sample (sample),
		.step   (state_q),
		.pair_a (pair_a),
		.pair_b (pair_b)
	);

	always_comb
	begin
		case (state_q)
			LANE_IDLE: state_d = start ? STEP0 : LANE_IDLE;
			STEP0: state_d = STEP1;
			STEP1: state_d = STEP2;
			STEP2: state_d = STEP3;
			STEP3: state_d = STEP4;
			default: state_d = LANE_IDLE;
		endcase
	end

	always_comb
	begin
		case (state_q)
			STEP0:
			begin
				coef_a = `FIR_C0;
				coef_b = `FIR_C1;
			end
			STEP1:
			begin
				coef_a = `FIR_C2;
				coef_b = `FIR_C3;
			end
			STEP2:
			begin
				coef_a = `FIR_C4;
				coef_b = `FIR_C5;
			end
			STEP3:
			begin
				coef_a = `FIR_C6;
				coef_b = `FIR_C7;
			end
			default:
			begin
				coef_a = `FIR_C8;
				coef_b = `FIR_C9;
			end
		endcase
	end

	assign prod_a = coef_a * pair_a;
	assign prod_b = coef_b * pair_b;
	assign acc_d = ((state_q == STEP0) ? acc_t'(0) : acc_q) + acc_t'(prod_a) + acc_t'(prod_b);
	assign busy = (state_q != LANE_IDLE);

	always_ff @(posedge clk, negedge resetn)
	begin
		if (!resetn)
		begin
			state_q <= LANE_IDLE;
			res_valid <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			res_valid <= (state_q == LAST_STEP);
		end
	end

	always_ff @(posedge clk)
	begin
		if (busy)
		begin
			acc_q <= acc_d;
		end
		if (state_q == LAST_STEP)
		begin
			res <= acc_d[`FIR_RES_LSB +: $bits(sample_t)]; // Plain truncation.
		end
	end

endmodule

// File: rtl/sample_distributor.sv
`include "fir_cfg.svh"

module sample_distributor (
	input  logic                     clk,
	input  logic                     resetn,
	input  logic                     in_valid,
	input  chan_pkg::in_beat_t       in_beat,
	input  logic [`FIR_LANES-1:0]    lane_busy,
	output logic [`FIR_LANES-1:0]    lane_start,
	output dsp_types_pkg::sample_t   lane_sample,
	output logic                     drop_valid,
	output chan_pkg::drop_t          drop_beat
);
	import dsp_types_pkg::*;
	import chan_pkg::*;

	logic in_valid_q;
	in_beat_t beat_q;
	logic [`FIR_LANES-1:0] pend_valid;
	sample_t pend_sample [`FIR_LANES];
	logic rel_hit;
	chan_t rel_lane;
	chan_t new_lane;
	logic direct;
	logic to_pend;

	// Lowest waiting lane that has gone idle.
	always_comb
	begin
		rel_hit = 1'b0;
		rel_lane = '0;
		for (int i = 0; i < `FIR_LANES; i++)
		begin
			if (!rel_hit && pend_valid[i] && !lane_busy[i])
			begin
				rel_hit = 1'b1;
				rel_lane = chan_t'(i);
			end
		end
	end

	assign new_lane = beat_q.chan;
	assign direct = in_valid_q && !lane_busy[new_lane] && !pend_valid[new_lane] && !rel_hit;
	assign to_pend = in_valid_q && !direct
		&& (!pend_valid[new_lane] || (rel_hit && rel_lane == new_lane));

	always_comb
	begin
		lane_start = '0;
		if (rel_hit)
		begin
			lane_start[rel_lane] = 1'b1;
		end
		else if (direct)
		begin
			lane_start[new_lane] = 1'b1;
		end
	end

	assign lane_sample = rel_hit ? pend_sample[rel_lane] : beat_q.sample;
	assign drop_valid = in_valid_q && !direct && !to_pend;
	assign drop_beat.chan = beat_q.chan;

	always_ff @(posedge clk, negedge resetn)
	begin
		if (!resetn)
		begin
			in_valid_q <= 1'b0;
			pend_valid <= '0;
		end
		else
		begin
			in_valid_q <= in_valid;
			if (rel_hit)
			begin
				pend_valid[rel_lane] <= 1'b0;
			end
			if (to_pend)
			begin
				pend_valid[new_lane] <= 1'b1; // Refill wins over release.
			end
		end
	end

	always_ff @(posedge clk)
	begin
		beat_q <= in_beat;
		if (to_pend)
		begin
			pend_sample[new_lane] <= beat_q.sample;
		end
	end

endmodule

// File: rtl/result_collector.sv
`include "fir_cfg.svh"

module result_collector (
	input  logic                     clk,
	input  logic                     resetn,
	input  logic [`FIR_LANES-1:0]    res_valid,
	input  dsp_types_pkg::sample_t   res [`FIR_LANES],
	output logic                     out_valid,
	output chan_pkg::out_beat_t      out_beat
);
	import dsp_types_pkg::*;
	import chan_pkg::*;

	logic [`FIR_LANES-1:0] slot_valid;
	sample_t slot_res [`FIR_LANES];
	chan_t last_q; // Lane served most recently.
	logic pick_hit;
	chan_t pick;

	// Round-robin search starting after the last lane served.
	always_comb
	begin
		int idx;
		pick_hit = 1'b0;
		pick = last_q;
		for (int i = 1; i <= `FIR_LANES; i++)
		begin
			idx = (int'(last_q) + i) % `FIR_LANES;
			if (!pick_hit && slot_valid[idx])
			begin
				pick_hit = 1'b1;
				pick = chan_t'(idx);
			end
		end
	end

	always_ff @(posedge clk, negedge resetn)
	begin
		if (!resetn)
		begin
			slot_valid <= '0;
			last_q <= chan_t'(`FIR_LANES - 1);
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= pick_hit;
			if (pick_hit)
			begin
				slot_valid[pick] <= 1'b0;
				last_q <= pick;
			end
			for (int i = 0; i < `FIR_LANES; i++)
			begin
				if (res_valid[i])
				begin
					slot_valid[i] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `FIR_LANES; i++)
		begin
			if (res_valid[i])
			begin
				slot_res[i] <= res[i];
			end
		end
		if (pick_hit)
		begin
			out_beat.chan <= pick;
			out_beat.result <= slot_res[pick];
		end
	end

endmodule

// File: rtl/fir_bank_top.sv
`include "fir_cfg.svh"

module fir_bank_top (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 in_valid,
	input  chan_pkg::in_beat_t   in_beat,
	output logic                 out_valid,
	output chan_pkg::out_beat_t  out_beat,
	output logic                 drop_valid,
	output chan_pkg::drop_t      drop_beat
);
	import dsp_types_pkg::*;

	logic [`FIR_LANES-1:0] lane_start;
	logic [`FIR_LANES-1:0] lane_busy;
	sample_t lane_sample; // Shared by all lanes.
	logic [`FIR_LANES-1:0] res_valid;
	sample_t res [`FIR_LANES];

	sample_distributor u_sample_distributor (
		.clk         (clk),
		.resetn      (resetn),
		.in_valid    (in_valid),
		.in_beat     (in_beat),
		.lane_busy   (lane_busy),
		.lane_start  (lane_start),
		.lane_sample (lane_sample),
		.drop_valid  (drop_valid),
		.drop_beat   (drop_beat)
	);

	for (genvar g = 0; g < `FIR_LANES; g++)
	begin : g_lane
		fir_lane u_fir_lane (
			.clk       (clk),
			.resetn    (resetn),
			.start     (lane_start[g]),
			.sample    (lane_sample),
			.busy      (lane_busy[g]),
			.res_valid (res_valid[g]),
			.res       (res[g])
		);
	end

	result_collector u_result_collector (
		.clk       (clk),
		.resetn    (resetn),
		.res_valid (res_valid),
		.res       (res),
		.out_valid (out_valid),
		.out_beat  (out_beat)
	);

endmodule

// File: bench/tb_fir_bank.sv
module tb_fir_bank;
	timeunit 1ns;
	timeprecision 1ps;

	import chan_pkg::*;

	localparam int N_CHAN = 2 ** $bits(chan_t);
	localparam int MAX_ITEMS = 64;
	localparam int RESET_CYCLES = 4;
	localparam int DRAIN_CYCLES = 20; // Room for stray outputs.

	logic clk;
	logic resetn;
	logic in_valid;
	in_beat_t in_beat;
	logic out_valid;
	out_beat_t out_beat;
	logic drop_valid;
	drop_t drop_beat;

	int beat_chan [MAX_ITEMS];
	int beat_smp [MAX_ITEMS];
	int beat_gap [MAX_ITEMS];
	int n_beats;
	int stim_len;
	int exp_val [N_CHAN][MAX_ITEMS]; // Per-channel queue, read at exp_head.
	int exp_cnt [N_CHAN];
	int exp_head [N_CHAN];
	int drop_exp [N_CHAN];
	int drop_seen [N_CHAN];
	int value_errors;
	int other_errors;
	int cycle_count;
	int cycle_limit;
	bit beats_started;

	fir_bank_top u_fir_bank_top (
		.clk        (clk),
		.resetn     (resetn),
		.in_valid   (in_valid),
		.in_beat    (in_beat),
		.out_valid  (out_valid),
		.out_beat   (out_beat),
		.drop_valid (drop_valid),
		.drop_beat  (drop_beat)
	);

	always #5 clk = ~clk;

	function automatic int results_left();
		int left = 0;
		for (int ch = 0; ch < N_CHAN; ch++)
			left += exp_cnt[ch] - exp_head[ch];
		return left;
	endfunction

	task automatic print_summary();
		$display("Summary: %0d value errors, %0d other errors.", value_errors, other_errors);
	endtask

	task automatic load_patterns();
		int fd;
		int kind;
		int ch;
		int a;
		int b;
		int c;
		fd = $fopen("bench/fir_patterns.txt", "r");
		assert (fd != 0)
		else
		begin
			$display("Could not open the pattern file bench/fir_patterns.txt.");
			other_errors++;
			return;
		end
		while ($fscanf(fd, " %c", kind) == 1)
		begin
			case (kind)
				"#":
				begin
					do
						ch = $fgetc(fd);
					while (ch != "\n" && ch != -1);
				end
				"B":
				begin
					void'($fscanf(fd, "%d %d %d", a, b, c));
					beat_chan[n_beats] = a;
					beat_smp[n_beats] = b;
					beat_gap[n_beats] = c;
					stim_len += c + 1;
					n_beats++;
				end
				"E":
				begin
					void'($fscanf(fd, "%d %d", a, b));
					exp_val[a][exp_cnt[a]] = b;
					exp_cnt[a]++;
				end
				"D":
				begin
					for (int i = 0; i < N_CHAN; i++)
						void'($fscanf(fd, "%d", drop_exp[i]));
				end
				default:
				begin
					$display("Pattern file holds a line of unknown kind.");
					other_errors++;
				end
			endcase
		end
		$fclose(fd);
	endtask

	task automatic check_result(input int chan, input int got);
		int want;
		assert (exp_head[chan] < exp_cnt[chan])
		else
		begin
			$display("Channel %0d gave result %0d at %0t with nothing left to expect.",
				chan, got, $time);
			other_errors++;
		end
		if (exp_head[chan] < exp_cnt[chan])
		begin
			want = exp_val[chan][exp_head[chan]];
			exp_head[chan]++;
			assert (got == want)
			else
			begin
				$display("ERROR at %0t: out_beat.result (channel %0d) expected %0d, got %0d",
					$time, chan, want, got);
				value_errors++;
			end
		end
	endtask

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit)
		begin
			$display("Timeout after %0d cycles, %0d results still missing.",
				cycle_count, results_left());
			print_summary();
			$display("TEST FAILED");
			$finish;
		end
	end

	// Outputs settle well before the falling edge.
	always @(negedge clk)
	begin
		if (resetn)
		begin
			if (!beats_started)
			begin
				assert (!out_valid && !drop_valid)
				else
				begin
					$display("Output strobe raised at %0t before any beat was sent.", $time);
					other_errors++;
				end
			end
			if (out_valid)
				check_result(out_beat.chan, out_beat.result);
			if (drop_valid)
				drop_seen[drop_beat.chan]++;
		end
	end

	initial
	begin
		$timeformat(-9, 0, " ns", 0);
		clk = 1'b0;
		resetn = 1'b0;
		in_valid = 1'b0;
		in_beat = '0;
		load_patterns();
		cycle_limit = RESET_CYCLES + stim_len + 60 * n_beats;
		repeat (RESET_CYCLES) @(posedge clk);
		resetn <= 1'b1;
		for (int i = 0; i < n_beats; i++)
		begin
			@(posedge clk);
			beats_started <= 1'b1;
			in_valid <= 1'b1;
			in_beat.chan <= chan_t'(beat_chan[i]);
			in_beat.sample <= beat_smp[i][4:0];
			repeat (beat_gap[i])
			begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
		while (results_left() > 0)
			@(negedge clk);
		repeat (DRAIN_CYCLES) @(negedge clk);
		for (int ch = 0; ch < N_CHAN; ch++)
		begin
			assert (drop_seen[ch] == drop_exp[ch])
			else
			begin
				$display("Channel %0d reported %0d dropped beats instead of %0d.",
					ch, drop_seen[ch], drop_exp[ch]);
				other_errors++;
			end
		end
		print_summary();
		if (value_errors == 0 && other_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: bench/fir_patterns.txt
# B chan sample idle_cycles | E chan result (in that channel's order) | D drops for chan 0 to 3
# All values are signed decimal.
B 0 15 5
B 0 0 5
B 0 0 5
B 0 0 5
B 0 0 5
B 0 0 5
B 0 0 5
B 0 0 5
B 0 0 5
B 0 0 9
B 0 -9 0
B 1 12 0
B 2 -16 0
B 3 9 2
B 0 6 0
B 1 -4 0
B 2 3 0
B 3 -11 9
B 1 7 0
B 1 -15 12
B 2 15 0
B 2 -8 0
B 2 13 12
B 2 2 0
E 0 0
E 0 -1
E 0 -1
E 0 0
E 0 0
E 0 -1
E 0 -2
E 0 -1
E 0 2
E 0 5
E 0 5
E 0 3
E 1 0
E 1 -1
E 1 0
E 1 0
E 2 -1
E 2 0
E 2 0
E 2 -1
E 2 -1
E 3 0
E 3 -1
D 0 0 1 0

// File: src.f
+incdir+rtl
rtl/dsp_types_pkg.sv
rtl/chan_pkg.sv
rtl/tap_delay_line.sv
rtl/fir_lane.sv
rtl/sample_distributor.sv
rtl/result_collector.sv
rtl/fir_bank_top.sv
bench/tb_fir_bank.sv

// File: Bender.yml
package:
  name: fir_bank

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dsp_types_pkg.sv
      - rtl/chan_pkg.sv
      - rtl/tap_delay_line.sv
      - rtl/fir_lane.sv
      - rtl/sample_distributor.sv
      - rtl/result_collector.sv
      - rtl/fir_bank_top.sv
  - target: test
    files:
      - bench/tb_fir_bank.sv
